// ==== bpu.f ====
hdl/bpu_cfg_pkg.sv
hdl/bpu_types_pkg.sv
hdl/lutram_dp.sv
hdl/bht.sv
hdl/fetch_pc_gen.sv
hdl/branch_resolve.sv
hdl/bpu_top.sv
testbench/bpu_tb.sv

// ==== Bender.yml ====
package:
  name: bpu

sources:
  - hdl/bpu_cfg_pkg.sv
  - hdl/bpu_types_pkg.sv
  - hdl/lutram_dp.sv
  - hdl/bht.sv
  - hdl/fetch_pc_gen.sv
  - hdl/branch_resolve.sv
  - hdl/bpu_top.sv
  - target: simulation
    files:
      - testbench/bpu_tb.sv

// ==== testbench/bpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_tb;

    localparam int PERIOD_NS = 100;
    localparam logic [11:0] PATTERN = 12'b0101_0000_1000;
    // reset, init sweep and the five tests
    localparam int RUN_CYCLES = 10 + bpu_cfg_pkg::INIT_CYCLES + 8 + 10 + 30 + 3 * 12 + 10;
    // twice the expected run
    localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES;
    // set 1 is kept for redirect steering only
    localparam bpu_cfg_pkg::addr_t STEER_PC = 32'h000f_ff04;

    logic                    clk;
    logic                    rst_n;
    logic                    stall;
    bpu_types_pkg::resolve_t resolve;
    bpu_cfg_pkg::addr_t      fetch_pc;
    bpu_types_pkg::predict_t predict;
    logic                    init_busy;
    logic                    redirect;
    bpu_cfg_pkg::addr_t      redirect_pc;

    int seed = 32'hf1f4;
    int errors;
    int test_errors;
    int tests;

    // reference model state
    logic                                     m_valid  [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS];
    logic                                     m_jump   [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS];
    logic [bpu_cfg_pkg::TAG_BITS-1:0]         m_tag    [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS];
    bpu_cfg_pkg::addr_t                       m_target [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS];
    logic [bpu_cfg_pkg::BH_BITS-1:0]          m_hist   [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS];
    logic [bpu_cfg_pkg::COUNTER_BITS-1:0]
        m_ctr [bpu_cfg_pkg::SET_NUM][bpu_cfg_pkg::WAYS][2**bpu_cfg_pkg::BH_BITS];
    logic                                     m_plru   [bpu_cfg_pkg::SET_NUM];
    bpu_types_pkg::bht_update_t               m_pend;
    logic                                     m_redir;
    bpu_cfg_pkg::addr_t                       m_redir_pc;
    bpu_cfg_pkg::addr_t                       exp_pc;
    int                                       m_init;

    bpu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .resolve    (resolve),
        .fetch_pc   (fetch_pc),
        .predict    (predict),
        .init_busy  (init_busy),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD_NS);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    // random address in set idx with bit 19 clear so offsets stay inside the tag
    function automatic bpu_cfg_pkg::addr_t pc_at_index(input int idx);
        logic [31:0] r;
        r = $random(seed);
        return {13'h0, r[18:7], idx[4:0], 2'b00};
    endfunction

    function automatic bpu_types_pkg::predict_t model_lookup(input bpu_cfg_pkg::addr_t pc,
                                                            output int si, output int wi);
        bpu_types_pkg::predict_t p;
        bpu_cfg_pkg::addr_t      a;
        p = '0;
        si = 0;
        wi = 0;
        // pc+4 first so the pc slot overrides it
        for (int s = 1; s >= 0; s--) begin
            a = pc + 32'(4 * s);
            for (int w = 0; w < bpu_cfg_pkg::WAYS; w++) begin
                if (m_valid[a[6:2]][w] && m_tag[a[6:2]][w] == a[19:2]) begin
                    si = a[6:2];
                    wi = w;
                    p.hit = 1'b1;
                    if (s == 0) begin
                        p.hit_pc = 1'b1;
                    end else begin
                        p.hit_pcp4 = 1'b1;
                    end
                end
            end
        end
        if (p.hit) begin
            p.is_jump    = m_jump[si][wi];
            p.dpre       = m_ctr[si][wi][m_hist[si][wi]][1];
            p.predict_pc = m_target[si][wi];
        end
        return p;
    endfunction

    function automatic void model_update(input bpu_types_pkg::bht_update_t u);
        int                               idx;
        int                               w;
        logic [bpu_cfg_pkg::BH_BITS-1:0]  h;
        idx = u.pc[6:2];
        w = -1;
        for (int i = 0; i < bpu_cfg_pkg::WAYS; i++) begin
            if (m_valid[idx][i] && m_tag[idx][i] == u.pc[19:2]) begin
                w = i;
            end
        end
        if (w >= 0) begin
            h = m_hist[idx][w];
            if (u.taken && m_ctr[idx][w][h] != 2'd3) begin
                m_ctr[idx][w][h] = m_ctr[idx][w][h] + 2'd1;
            end else if (!u.taken && m_ctr[idx][w][h] != 2'd0) begin
                m_ctr[idx][w][h] = m_ctr[idx][w][h] - 2'd1;
            end
            m_hist[idx][w] = {h[2:0], u.taken};
        end else begin
            w = m_plru[idx];
            m_valid[idx][w]  = 1'b1;
            m_tag[idx][w]    = u.pc[19:2];
            m_jump[idx][w]   = u.is_jump;
            m_target[idx][w] = u.dest_pc;
            m_hist[idx][w]   = '0;
            for (int c = 0; c < 2**bpu_cfg_pkg::BH_BITS; c++) begin
                m_ctr[idx][w][c] = 2'd3;
            end
        end
    endfunction

    always @(posedge clk or negedge rst_n) begin : model
        bpu_types_pkg::predict_t lk;
        int li;
        int lw;
        if (!rst_n) begin
            for (int s = 0; s < bpu_cfg_pkg::SET_NUM; s++) begin
                m_plru[s] = 1'b0;
                for (int w = 0; w < bpu_cfg_pkg::WAYS; w++) begin
                    m_valid[s][w] = 1'b0;
                end
            end
            m_pend = '0;
            m_redir = 1'b0;
            m_redir_pc = '0;
            exp_pc = '0;
            m_init = 0;
        end else begin
            // lookup sees the table as it was before this edge
            lk = model_lookup(exp_pc, li, lw);
            if (m_pend.write) begin
                model_update(m_pend);
            end
            if (lk.hit) begin
                m_plru[li] = (lw == 0);
            end
            if (m_redir) begin
                exp_pc = m_redir_pc;
            end else if (!stall && m_init == bpu_cfg_pkg::INIT_CYCLES) begin
                exp_pc = (lk.hit && (lk.is_jump || lk.dpre)) ? lk.predict_pc : exp_pc + 32'd8;
            end
            if (m_init < bpu_cfg_pkg::INIT_CYCLES) begin
                m_init++;
            end
            m_pend = '{write: resolve.valid && resolve.is_branch_or_jump, pc: resolve.pc,
                       is_jump: resolve.is_jump, taken: resolve.taken, dest_pc: resolve.target};
            m_redir = m_pend.write && ((resolve.pred_taken != resolve.taken) ||
                      (resolve.taken && resolve.pred_target != resolve.target));
            m_redir_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
            test_errors++;
        end
    endtask

    task automatic check_state();
        bpu_types_pkg::predict_t exp;
        int si;
        int wi;
        exp = model_lookup(exp_pc, si, wi);
        check_val("fetch_pc", fetch_pc, exp_pc);
        check_val("predict", predict, exp);
        check_val("redirect", redirect, m_redir);
        if (m_redir) begin
            check_val("redirect_pc", redirect_pc, m_redir_pc);
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d mismatches", name, test_errors);
        end
        errors += test_errors;
        test_errors = 0;
        tests++;
    endtask

    // starts on a falling edge and returns one falling edge later
    task automatic drive_resolve(input bpu_cfg_pkg::addr_t bpc, input logic jump,
                                 input logic taken, input bpu_cfg_pkg::addr_t target,
                                 input logic ptaken, input bpu_cfg_pkg::addr_t ptarget);
        resolve = '{valid: 1'b1, pc: bpc, is_branch_or_jump: 1'b1, is_jump: jump,
                    taken: taken, target: target, pred_taken: ptaken, pred_target: ptarget};
        @(negedge clk);
        resolve = '0;
    endtask

    // a mispredicted jump from the steering pc moves fetch even under stall
    task automatic steer_fetch(input bpu_cfg_pkg::addr_t to);
        drive_resolve(STEER_PC, 1'b1, 1'b1, to, 1'b0, '0);
        @(negedge clk);
        check_val("fetch_pc", fetch_pc, to);
    endtask

    task automatic test_init_miss();
        int cnt;
        cnt = 0;
        while (init_busy && cnt < 4 * bpu_cfg_pkg::INIT_CYCLES) begin
            check_state();
            @(negedge clk);
            cnt++;
        end
        check_val("init_busy cycles", cnt, bpu_cfg_pkg::INIT_CYCLES);
        for (int i = 0; i < 8; i++) begin
            check_state();
            check_val("fetch_pc", fetch_pc, 8 * i);
            check_val("predict.hit", predict.hit, 0);
            @(negedge clk);
        end
        report_test("init_and_miss");
    endtask

    task automatic test_allocate();
        bpu_cfg_pkg::addr_t p;
        bpu_cfg_pkg::addr_t t;
        p = pc_at_index(8);
        t = pc_at_index(30);
        stall = 1'b1;
        steer_fetch(p);
        check_val("predict.hit", predict.hit, 0);
        drive_resolve(p, 1'b0, 1'b1, t, 1'b1, t);
        // registered but not yet written
        check_val("predict.hit", predict.hit, 0);
        @(negedge clk);
        check_state();
        check_val("predict.hit_pc", predict.hit_pc, 1);
        check_val("predict.dpre", predict.dpre, 1);
        check_val("predict.predict_pc", predict.predict_pc, t);
        stall = 1'b0;
        @(negedge clk);
        check_val("fetch_pc", fetch_pc, t);
        check_state();
        stall = 1'b1;
        report_test("allocate");
    endtask

    task automatic test_pcp4_jump();
        bpu_cfg_pkg::addr_t p;
        bpu_cfg_pkg::addr_t t;
        bpu_cfg_pkg::addr_t victim;
        int v;
        p = pc_at_index(12);
        t = pc_at_index(30);
        steer_fetch(p);
        drive_resolve(p + 32'd4, 1'b1, 1'b1, t, 1'b1, t);
        @(negedge clk);
        check_state();
        check_val("predict.hit_pc", predict.hit_pc, 0);
        check_val("predict.hit_pcp4", predict.hit_pcp4, 1);
        check_val("predict.is_jump", predict.is_jump, 1);
        check_val("predict.predict_pc", predict.predict_pc, t);
        stall = 1'b0;
        @(negedge clk);
        check_val("fetch_pc", fetch_pc, t);
        stall = 1'b1;
        // fetch parked on p keeps set 13 pointing away from the jump
        steer_fetch(p);
        drive_resolve(p + 32'h84, 1'b0, 1'b1, t, 1'b1, t);
        @(negedge clk);
        v = m_plru[13];
        victim = {12'h0, m_tag[13][v], 2'b00};
        drive_resolve(p + 32'h104, 1'b0, 1'b1, t, 1'b1, t);
        @(negedge clk);
        steer_fetch(victim - 32'd4);
        check_state();
        check_val("predict.hit_pcp4", predict.hit_pcp4, 0);
        steer_fetch(p + 32'h100);
        check_state();
        check_val("predict.hit_pcp4", predict.hit_pcp4, 1);
        report_test("pcp4_jump_evict");
    endtask

    task automatic test_training();
        bpu_types_pkg::predict_t exp;
        bpu_cfg_pkg::addr_t b;
        bpu_cfg_pkg::addr_t t;
        int si;
        int wi;
        b = pc_at_index(20);
        t = pc_at_index(28);
        steer_fetch(b);
        drive_resolve(b, 1'b0, 1'b1, t, 1'b1, t);
        @(negedge clk);
        for (int i = 0; i < 12; i++) begin
            drive_resolve(b, 1'b0, PATTERN[i], t, PATTERN[i], t);
            @(negedge clk);
            exp = model_lookup(b, si, wi);
            check_val("predict.dpre", predict.dpre, exp.dpre);
            check_state();
        end
        report_test("training");
    endtask

    task automatic test_mispredict();
        bpu_cfg_pkg::addr_t r;
        bpu_cfg_pkg::addr_t x;
        r = pc_at_index(25);
        x = pc_at_index(26);
        stall = 1'b1;
        // predicted taken but fell through
        drive_resolve(r, 1'b0, 1'b0, x, 1'b1, x);
        check_state();
        check_val("redirect", redirect, 1);
        check_val("redirect_pc", redirect_pc, r + 32'd4);
        @(negedge clk);
        check_val("fetch_pc", fetch_pc, r + 32'd4);
        // taken to the wrong target
        drive_resolve(r, 1'b0, 1'b1, x, 1'b1, x + 32'd8);
        check_val("redirect", redirect, 1);
        check_val("redirect_pc", redirect_pc, x);
        @(negedge clk);
        check_val("fetch_pc", fetch_pc, x);
        check_state();
        stall = 1'b0;
        report_test("mispredict");
    endtask

    initial begin
        rst_n = 1'b0;
        stall = 1'b0;
        resolve = '0;
        errors = 0;
        test_errors = 0;
        tests = 0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        test_init_miss();
        test_allocate();
        test_pcp4_jump();
        test_training();
        test_mispredict();
        $display("%0d tests run, %0d mismatches", tests, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/bpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module bpu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  bpu_types_pkg::resolve_t resolve,
    output bpu_cfg_pkg::addr_t      fetch_pc,
    output bpu_types_pkg::predict_t predict,
    output logic                    init_busy,
    output logic                    redirect,
    output bpu_cfg_pkg::addr_t      redirect_pc
);

    // registered table write from resolve into the bht
    bpu_types_pkg::bht_update_t update;

    fetch_pc_gen u_fetch_pc_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .init_busy  (init_busy),
        .predict    (predict),
        .redirect   (redirect),
        .redirect_pc(redirect_pc),
        .fetch_pc   (fetch_pc)
    );

    bht u_bht (
        .clk      (clk),
        .rst_n    (rst_n),
        .fetch_pc (fetch_pc),
        .predict  (predict),
        .update   (update),
        .init_busy(init_busy)
    );

    branch_resolve u_branch_resolve (
        .clk        (clk),
        .rst_n      (rst_n),
        .resolve    (resolve),
        .update     (update),
        .redirect   (redirect),
        .redirect_pc(redirect_pc)
    );

endmodule

`default_nettype wire

// ==== hdl/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_resolve (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bpu_types_pkg::resolve_t    resolve,
    output bpu_types_pkg::bht_update_t update,
    output logic                       redirect,
    output bpu_cfg_pkg::addr_t         redirect_pc
);

    logic               capture;
    logic               dir_wrong;
    logic               tgt_wrong;
    bpu_cfg_pkg::addr_t fix_pc;

    assign capture = resolve.valid && resolve.is_branch_or_jump;

    // wrong direction, or taken to the wrong place
    assign dir_wrong = resolve.pred_taken != resolve.taken;
    assign tgt_wrong = resolve.taken && (resolve.pred_target != resolve.target);

    // fall-through after a branch predicted taken
    assign fix_pc = resolve.taken ? resolve.target : resolve.pc + 32'd4;

    // update is a single-cycle pulse, write drops when nothing resolves
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            update      <= '0;
            redirect    <= 1'b0;
            redirect_pc <= '0;
        end else begin
            update.write   <= capture;
            update.pc      <= resolve.pc;
            update.is_jump <= resolve.is_jump;
            update.taken   <= resolve.taken;
            update.dest_pc <= resolve.target;
            redirect       <= capture && (dir_wrong || tgt_wrong);
            redirect_pc    <= fix_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    stall,
    input  logic                    init_busy,
    input  bpu_types_pkg::predict_t predict,
    input  logic                    redirect,
    input  bpu_cfg_pkg::addr_t      redirect_pc,
    output bpu_cfg_pkg::addr_t      fetch_pc
);

    bpu_cfg_pkg::addr_t next_pc;
    logic               pred_redirect;

    // taken when the entry is a jump or its counter says taken
    assign pred_redirect = predict.hit && (predict.is_jump || predict.dpre);

    always_comb begin
        if (pred_redirect) begin
            next_pc = predict.predict_pc;
        end else begin
            next_pc = fetch_pc + bpu_cfg_pkg::addr_t'(bpu_cfg_pkg::FETCH_STEP);
        end
    end

    // a mispredict overrides stall and the init sweep
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= '0;
        end else if (redirect) begin
            fetch_pc <= redirect_pc;
        end else if (!stall && !init_busy) begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bht.sv ====
`timescale 1ns/1ps
`default_nettype none

module bht (
    input  logic                       clk,
    input  logic                       rst_n,
    input  bpu_cfg_pkg::addr_t         fetch_pc,
    output bpu_types_pkg::predict_t    predict,
    input  bpu_types_pkg::bht_update_t update,
    output logic                       init_busy
);

    function automatic logic [bpu_cfg_pkg::INDEX_BITS-1:0] get_index(bpu_cfg_pkg::addr_t a);
        return a[bpu_cfg_pkg::INDEX_BITS+1:2];
    endfunction

    function automatic logic [bpu_cfg_pkg::TAG_BITS-1:0] get_tag(bpu_cfg_pkg::addr_t a);
        return a[bpu_cfg_pkg::TAG_BITS+1:2];
    endfunction

    // a meta row holds an even/odd set pair, so one read covers pc and pc+4
    bpu_types_pkg::bht_meta_t [1:0][bpu_cfg_pkg::WAYS-1:0] meta_rd_row;
    bpu_types_pkg::bht_meta_t [1:0][bpu_cfg_pkg::WAYS-1:0] meta_upd_row;
    bpu_types_pkg::bht_meta_t [1:0][bpu_cfg_pkg::WAYS-1:0] meta_wr_row;
    logic [bpu_cfg_pkg::INDEX_BITS-2:0]                      meta_waddr;

    bpu_types_pkg::bh_data_t bh_pred, bh_upd, bh_wr;
    logic [2**bpu_cfg_pkg::BH_BITS-1:0][bpu_cfg_pkg::COUNTER_BITS-1:0] ctr_pred;
    logic [2**bpu_cfg_pkg::BH_BITS-1:0][bpu_cfg_pkg::COUNTER_BITS-1:0] ctr_upd;
    logic [2**bpu_cfg_pkg::BH_BITS-1:0][bpu_cfg_pkg::COUNTER_BITS-1:0] ctr_wr;
    logic [bpu_cfg_pkg::COUNTER_BITS-1:0] ctr_old, ctr_new;

    // lookup side
    bpu_cfg_pkg::addr_t [1:0]                        slot_pc;
    logic [1:0]                                      slot_hit;
    logic [1:0]                                      slot_jump;
    logic [1:0][bpu_cfg_pkg::WAY_BITS-1:0]           slot_way;
    logic                                            lk_hit;
    logic                                            lk_jump;
    bpu_types_pkg::bht_ram_addr_t                    lk_addr;

    // update side
    logic [bpu_cfg_pkg::INDEX_BITS-1:0]  upd_idx;
    logic [bpu_cfg_pkg::WAY_BITS-1:0]    upd_hit_way;
    logic [bpu_cfg_pkg::WAY_BITS-1:0]    repl_way;
    logic                                in_bht;
    logic                                ram_we;
    bpu_types_pkg::bht_ram_addr_t        upd_addr;

    logic [bpu_cfg_pkg::SET_NUM-1:0]                     plru;
    logic [$bits(bpu_types_pkg::bht_ram_addr_t)-1:0]     sweep_cnt;
    bpu_types_pkg::bht_ram_addr_t                        sweep_addr;

    assign sweep_addr = sweep_cnt;

    // tag both slots, tag holds the index bits so a pc+4 in the next row never matches
    always_comb begin
        bpu_types_pkg::bht_meta_t cand;
        slot_pc[0] = fetch_pc;
        slot_pc[1] = fetch_pc + 32'd4;
        slot_hit   = '0;
        slot_jump  = '0;
        slot_way   = '0;
        for (int s = 0; s < 2; s++) begin
            for (int w = 0; w < bpu_cfg_pkg::WAYS; w++) begin
                cand = meta_rd_row[slot_pc[s][2]][w];
                if (!init_busy && cand.valid && cand.tag == get_tag(slot_pc[s])) begin
                    slot_hit[s]  = 1'b1;
                    slot_jump[s] = cand.is_jump;
                    slot_way[s]  = w[bpu_cfg_pkg::WAY_BITS-1:0];
                end
            end
        end
    end

    // slot pc wins over pc+4
    always_comb begin
        lk_hit  = |slot_hit;
        lk_jump = 1'b0;
        lk_addr = '0;
        if (slot_hit[0]) begin
            lk_jump = slot_jump[0];
            lk_addr = '{index: get_index(slot_pc[0]), way: slot_way[0]};
        end else if (slot_hit[1]) begin
            lk_jump = slot_jump[1];
            lk_addr = '{index: get_index(slot_pc[1]), way: slot_way[1]};
        end
    end

    always_comb begin
        predict.hit        = lk_hit;
        predict.hit_pc     = slot_hit[0];
        predict.hit_pcp4   = slot_hit[1];
        predict.is_jump    = lk_jump;
        predict.dpre       = lk_hit & ctr_pred[bh_pred.history][bpu_cfg_pkg::COUNTER_BITS-1];
        predict.predict_pc = lk_hit ? bh_pred.target : '0;
    end

    // executed pc against its own set
    assign upd_idx = get_index(update.pc);

    always_comb begin
        in_bht      = 1'b0;
        upd_hit_way = '0;
        for (int w = 0; w < bpu_cfg_pkg::WAYS; w++) begin
            if (meta_upd_row[upd_idx[0]][w].valid &&
                meta_upd_row[upd_idx[0]][w].tag == get_tag(update.pc)) begin
                in_bht      = 1'b1;
                upd_hit_way = w[bpu_cfg_pkg::WAY_BITS-1:0];
            end
        end
    end

    assign repl_way = plru[upd_idx];
    assign upd_addr = init_busy ? sweep_addr
                                : '{index: upd_idx, way: in_bht ? upd_hit_way : repl_way};
    assign meta_waddr = init_busy ? sweep_addr.index[bpu_cfg_pkg::INDEX_BITS-1:1]
                                  : upd_idx[bpu_cfg_pkg::INDEX_BITS-1:1];
    assign ram_we = init_busy | update.write;

    // 2-bit saturating step on the counter picked by the old history
    always_comb begin
        ctr_old = ctr_upd[bh_upd.history];
        if (update.taken) begin
            ctr_new = (ctr_old == '1) ? ctr_old : ctr_old + 1'b1;
        end else begin
            ctr_new = (ctr_old == '0) ? ctr_old : ctr_old - 1'b1;
        end
    end

    always_comb begin
        meta_wr_row = '0;
        bh_wr       = '0;
        ctr_wr      = '1;
        if (!init_busy) begin
            meta_wr_row = meta_upd_row;
            if (in_bht) begin
                // train: shift in the outcome, keep the target
                bh_wr.target  = bh_upd.target;
                bh_wr.history = {bh_upd.history[bpu_cfg_pkg::BH_BITS-2:0], update.taken};
                ctr_wr                  = ctr_upd;
                ctr_wr[bh_upd.history]  = ctr_new;
            end else begin
                // allocate the plru way with counters strongly taken
                meta_wr_row[upd_idx[0]][repl_way] = '{
                    valid:   1'b1,
                    is_jump: update.is_jump,
                    tag:     get_tag(update.pc)
                };
                bh_wr.target  = update.dest_pc;
                bh_wr.history = '0;
            end
        end
    end

    // point the set's bit away from the way that just hit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            plru <= '0;
        end else if (lk_hit) begin
            plru[lk_addr.index] <= ~lk_addr.way;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweep_cnt <= '0;
            init_busy <= 1'b1;
        end else if (init_busy) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (sweep_cnt == bpu_cfg_pkg::INIT_CYCLES - 1) begin
                init_busy <= 1'b0;
            end
        end
    end

    lutram_dp #(
        .ADDR_WIDTH(bpu_cfg_pkg::INDEX_BITS - 1),
        .DATA_WIDTH($bits(bpu_types_pkg::bht_meta_t) * 2 * bpu_cfg_pkg::WAYS)
    ) meta_ram (
        .clk    (clk),
        .we     (ram_we),
        .waddr  (meta_waddr),
        .wdata  (meta_wr_row),
        .rdata_w(meta_upd_row),
        .raddr  (fetch_pc[bpu_cfg_pkg::INDEX_BITS+1:3]),
        .rdata_r(meta_rd_row)
    );

    lutram_dp #(
        .ADDR_WIDTH($bits(bpu_types_pkg::bht_ram_addr_t)),
        .DATA_WIDTH($bits(bpu_types_pkg::bh_data_t))
    ) bh_data_ram (
        .clk    (clk),
        .we     (ram_we),
        .waddr  (upd_addr),
        .wdata  (bh_wr),
        .rdata_w(bh_upd),
        .raddr  (lk_addr),
        .rdata_r(bh_pred)
    );

    lutram_dp #(
        .ADDR_WIDTH($bits(bpu_types_pkg::bht_ram_addr_t)),
        .DATA_WIDTH(bpu_cfg_pkg::COUNTER_BITS * (2**bpu_cfg_pkg::BH_BITS))
    ) counter_ram (
        .clk    (clk),
        .we     (ram_we),
        .waddr  (upd_addr),
        .wdata  (ctr_wr),
        .rdata_w(ctr_upd),
        .raddr  (lk_addr),
        .rdata_r(ctr_pred)
    );

endmodule

`default_nettype wire

// ==== hdl/lutram_dp.sv ====
`timescale 1ns/1ps
`default_nettype none

module lutram_dp #(
    parameter int ADDR_WIDTH = 5,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,

    // read/write port
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] wdata,
    output logic [DATA_WIDTH-1:0] rdata_w,

    // read-only port
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0] rdata_r
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both reads are asynchronous, old data seen until the edge
    assign rdata_w = mem[waddr];
    assign rdata_r = mem[raddr];

endmodule

`default_nettype wire

// ==== hdl/bpu_types_pkg.sv ====
`default_nettype none

package bpu_types_pkg;

    typedef struct packed {
        logic                              valid;
        logic                              is_jump;
        logic [bpu_cfg_pkg::TAG_BITS-1:0]  tag;
    } bht_meta_t;

    typedef struct packed {
        bpu_cfg_pkg::addr_t               target;
        logic [bpu_cfg_pkg::BH_BITS-1:0]  history;
    } bh_data_t;

    // one entry of the target and counter tables
    typedef struct packed {
        logic [bpu_cfg_pkg::INDEX_BITS-1:0]  index;
        logic [bpu_cfg_pkg::WAY_BITS-1:0]    way;
    } bht_ram_addr_t;

    // travels with the fetched pair
    typedef struct packed {
        logic                hit;
        logic                hit_pc;
        logic                hit_pcp4;
        logic                is_jump;
        logic                dpre;
        bpu_cfg_pkg::addr_t  predict_pc;
    } predict_t;

    typedef struct packed {
        logic                valid;
        bpu_cfg_pkg::addr_t  pc;
        logic                is_branch_or_jump;
        logic                is_jump;
        logic                taken;
        bpu_cfg_pkg::addr_t  target;
        logic                pred_taken;
        bpu_cfg_pkg::addr_t  pred_target;
    } resolve_t;

    typedef struct packed {
        logic                write;
        bpu_cfg_pkg::addr_t  pc;
        logic                is_jump;
        logic                taken;
        bpu_cfg_pkg::addr_t  dest_pc;
    } bht_update_t;

endpackage

`default_nettype wire

// ==== hdl/bpu_cfg_pkg.sv ====
`default_nettype none

package bpu_cfg_pkg;

    typedef logic [31:0] addr_t;

    // table geometry
    localparam int WAYS = 2;
    localparam int WAY_BITS = $clog2(WAYS);
    localparam int SET_NUM = 32;
    localparam int INDEX_BITS = 5;
    localparam int TAG_BITS = 18;

    // local history and its counter table
    localparam int BH_BITS = 4;
    localparam int COUNTER_BITS = 2;

    // bytes covered by one fetch pair
    localparam int FETCH_STEP = 8;

    // one clearing write per table entry
    localparam int INIT_CYCLES = SET_NUM * WAYS;

endpackage

`default_nettype wire
